//--- bench/issue_checker.sv
// ----------------------------------------------------------
// Checker for the issue slice
// In-order reference model, writeback comparison,
// flush tracking, ordering and stall checks, test reports
// ----------------------------------------------------------

`include "iq_settings.svh"

module issue_checker
   import iq_pkg::*;
(
   input  logic                clk,
   input  logic                i_arst_n,
   input  logic                i_valid,
   input  uop_t                i_uop,
   input  logic                i_ready,
   input  logic                i_flush,
   input  bypass_t             i_wb,
   input  logic                i_stall_exp,
   input  logic [1:0]          i_ord_kind,
   input  logic [`IQ_ID_W-1:0] i_ord_ref,
   input  logic                i_test_end,
   input  int                  i_test_num,
   output int                  o_pending,
   output int                  o_tests_pass,
   output int                  o_tests_fail,
   output int                  o_errors
);

   timeunit 1ns;
   timeprecision 100ps;

   localparam int NID = 1 << `IQ_ID_W;
   localparam int NREG = 1 << `IQ_REG_AW;
   localparam logic [1:0] ORD_BEFORE = 2'd1;
   localparam logic [1:0] ORD_AFTER = 2'd2;

   logic [`IQ_DATA_W-1:0] mreg     [NREG];
   logic [`IQ_DATA_W-1:0] exp_data [NID];
   logic [`IQ_DATA_W-1:0] old_val  [NID];
   logic [`IQ_REG_AW-1:0] exp_rd   [NID];
   logic [1:0]            ord_kind [NID];
   logic [`IQ_ID_W-1:0]   ord_ref  [NID];
   logic [NID-1:0]        pend;
   logic [NID-1:0]        flushed;
   logic [NID-1:0]        seen;
   logic                  stalled;
   int                    test_errs;

   assign o_pending = $countones(pend);

   initial
   begin
      for (int i = 0; i < NREG; i++)
         mreg[i] = '0;
      pend         = '0;
      flushed      = '0;
      seen         = '0;
      stalled      = 1'b0;
      test_errs    = 0;
      o_tests_pass = 0;
      o_tests_fail = 0;
      o_errors     = 0;
   end

   // Program-order execution on the model register file
   function automatic logic [`IQ_DATA_W-1:0] model_result(input uop_t u);
      logic [`IQ_DATA_W-1:0] a;
      logic [`IQ_DATA_W-1:0] b;
      a = mreg[u.rs1];
      b = mreg[u.rs2];
      case (u.op)
         OP_ADD:  model_result = a + b;
         OP_SUB:  model_result = a - b;
         OP_XOR:  model_result = a ^ b;
         OP_LI:   model_result = {16'h0000, u.imm};
         OP_MUL:  model_result = a * b;
         default: model_result = '0;
      endcase
   endfunction

   task automatic note_error();
      test_errs++;
      o_errors++;
   endtask

   task automatic check_writeback();
      logic [`IQ_ID_W-1:0] id;
      id = i_wb.id;
      if (flushed[id])
      begin
         $display("Error: writeback seen for flushed micro-op id %0h", id);
         note_error();
      end
      else if (!pend[id])
      begin
         $display("Error: writeback for micro-op id %0h that is not outstanding", id);
         note_error();
      end
      else
      begin
         if (i_wb.rd !== exp_rd[id])
         begin
            $display("FAIL o_wb.rd id %0h: got %h expected %h", id, i_wb.rd, exp_rd[id]);
            note_error();
         end
         if (i_wb.data !== exp_data[id])
         begin
            $display("FAIL o_wb.data id %0h: got %h expected %h", id, i_wb.data, exp_data[id]);
            note_error();
         end
         if (ord_kind[id] == ORD_BEFORE && seen[ord_ref[id]])
         begin
            $display("Error: id %0h wrote back after id %0h instead of before", id, ord_ref[id]);
            note_error();
         end
         if (ord_kind[id] == ORD_AFTER && !seen[ord_ref[id]])
         begin
            $display("Error: id %0h wrote back before id %0h instead of after", id, ord_ref[id]);
            note_error();
         end
         pend[id] = 1'b0;
         seen[id] = 1'b1;
      end
   endtask

   // Outstanding work vanishes and its destinations fall back
   task automatic drop_flushed();
      for (int i = 0; i < NID; i++)
      begin
         if (pend[i])
         begin
            pend[i]    = 1'b0;
            flushed[i] = 1'b1;
            if (exp_rd[i] != '0)
               mreg[exp_rd[i]] = old_val[i];
         end
      end
   endtask

   task automatic track_dispatch();
      logic [`IQ_ID_W-1:0]   id;
      logic [`IQ_DATA_W-1:0] res;
      id = i_uop.id;
      if (!i_ready)
         stalled = 1'b1;
      else
      begin
         if (i_stall_exp && !stalled)
         begin
            $display("Error: micro-op id %0h was accepted without the expected stall", id);
            note_error();
         end
         if (pend[id])
         begin
            $display("Error: micro-op id %0h reused while still outstanding", id);
            note_error();
         end
         stalled      = 1'b0;
         res          = model_result(i_uop);
         exp_rd[id]   = i_uop.rd;
         exp_data[id] = res;
         old_val[id]  = mreg[i_uop.rd];
         ord_kind[id] = i_ord_kind;
         ord_ref[id]  = i_ord_ref;
         pend[id]     = 1'b1;
         flushed[id]  = 1'b0;
         seen[id]     = 1'b0;
         if (i_uop.rd != '0)
            mreg[i_uop.rd] = res;
      end
   endtask

   task automatic close_test();
      for (int i = 0; i < NID; i++)
      begin
         if (pend[i])
         begin
            $display("Error: micro-op id %0h was never written back", i);
            note_error();
            pend[i] = 1'b0;
         end
      end
      if (test_errs == 0)
      begin
         $display("Test %0d: ok", i_test_num);
         o_tests_pass++;
      end
      else
      begin
         $display("Test %0d: %0d error(s)", i_test_num, test_errs);
         o_tests_fail++;
      end
      test_errs = 0;
   endtask

   // Mid-cycle sample shows what the next rising edge acts on
   always @(negedge clk)
   begin
      if (i_arst_n)
      begin
         if (i_wb.valid)
            check_writeback();
         if (i_flush)
            drop_flushed();
         if (i_valid)
            track_dispatch();
         if (i_test_end)
            close_test();
      end
   end

endmodule

//--- bench/tb_issue.sv
// ----------------------------------------------------------
// Testbench for the issue slice
// Clock, reset, stimulus table, dispatch loop and timeout
// ----------------------------------------------------------

`include "iq_settings.svh"

module tb_issue
   import iq_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int MAX_ROWS = 96;
   localparam int DRAIN_MAX = 60;
   localparam logic [1:0] ORD_BEFORE = 2'd1;
   localparam logic [1:0] ORD_AFTER = 2'd2;

   typedef struct packed
   {
      uop_t       uop;
      logic       flush_after;
      logic       stall;
      logic [1:0] ord_kind;
      int         ord_row;
      int         test;
   } row_t;

   logic                clk;
   logic                i_arst_n;
   logic                i_valid;
   uop_t                i_uop;
   logic                i_flush;
   logic                o_ready;
   bypass_t             o_wb;
   logic                stall_exp;
   logic [1:0]          ord_kind;
   logic [`IQ_ID_W-1:0] ord_ref;
   logic                test_end;
   int                  test_num;
   int                  pending;
   int                  tests_pass;
   int                  tests_fail;
   int                  errors;

   row_t tab [MAX_ROWS];
   int   n_rows;
   int   cur_test;
   int   cycles = 0;
   int   limit = 0;

   issue_top UUT (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_valid  (i_valid),
      .i_uop    (i_uop),
      .i_flush  (i_flush),
      .o_ready  (o_ready),
      .o_wb     (o_wb)
   );

   issue_checker u_check (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_valid      (i_valid),
      .i_uop        (i_uop),
      .i_ready      (o_ready),
      .i_flush      (i_flush),
      .i_wb         (o_wb),
      .i_stall_exp  (stall_exp),
      .i_ord_kind   (ord_kind),
      .i_ord_ref    (ord_ref),
      .i_test_end   (test_end),
      .i_test_num   (test_num),
      .o_pending    (pending),
      .o_tests_pass (tests_pass),
      .o_tests_fail (tests_fail),
      .o_errors     (errors)
   );

   always #10 clk = ~clk;

   always @(posedge clk)
   begin
      cycles++;
      if (limit > 0 && cycles >= limit)
      begin
         $display("Timeout: run did not finish within %0d cycles", limit);
         $display("Done: errors found");
         $finish;
      end
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      lcg_next = s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [`IQ_ID_W-1:0] row_id(input int r);
      row_id = r[`IQ_ID_W-1:0];
   endfunction

   task automatic add_op(input op_e op, input int rd, input int rs1, input int rs2,
                         input logic [15:0] imm);
      row_t row;
      row         = '0;
      row.uop.op  = op;
      row.uop.rd  = rd[`IQ_REG_AW-1:0];
      row.uop.rs1 = rs1[`IQ_REG_AW-1:0];
      row.uop.rs2 = rs2[`IQ_REG_AW-1:0];
      row.uop.imm = imm;
      row.test    = cur_test;
      tab[n_rows] = row;
      n_rows++;
   endtask

   task automatic build_table();
      logic [31:0] seed;
      logic [31:0] pick;
      int          m;
      n_rows   = 0;
      // ALU basics and r0
      cur_test = 1;
      add_op(OP_LI, 1, 0, 0, 16'h1234);
      add_op(OP_LI, 2, 0, 0, 16'h00ff);
      add_op(OP_ADD, 3, 1, 2, 16'h0);
      add_op(OP_SUB, 4, 2, 1, 16'h0);
      add_op(OP_XOR, 5, 1, 2, 16'h0);
      add_op(OP_LI, 0, 3, 4, 16'hbeef);
      add_op(OP_ADD, 6, 0, 1, 16'h0);
      add_op(OP_LI, 7, 5, 6, 16'h8001);
      // Dependency chain through wake-up
      cur_test = 2;
      add_op(OP_LI, 8, 0, 0, 16'h0005);
      add_op(OP_ADD, 9, 8, 8, 16'h0);
      add_op(OP_SUB, 10, 9, 8, 16'h0);
      add_op(OP_XOR, 11, 10, 9, 16'h0);
      add_op(OP_ADD, 12, 11, 10, 16'h0);
      add_op(OP_MUL, 13, 12, 9, 16'h0);
      add_op(OP_ADD, 14, 13, 1, 16'h0);
      // Younger independent work overtakes a waiting MUL
      cur_test = 3;
      add_op(OP_MUL, 20, 1, 2, 16'h0);
      m = n_rows;
      add_op(OP_MUL, 21, 20, 1, 16'h0);
      add_op(OP_ADD, 22, 21, 2, 16'h0);
      tab[n_rows-1].ord_kind = ORD_AFTER;
      tab[n_rows-1].ord_row  = m;
      add_op(OP_ADD, 23, 1, 2, 16'h0);
      tab[n_rows-1].ord_kind = ORD_BEFORE;
      tab[n_rows-1].ord_row  = m;
      // Queue fills behind a MUL chain
      cur_test = 4;
      add_op(OP_MUL, 6, 1, 2, 16'h0);
      add_op(OP_MUL, 7, 6, 1, 16'h0);
      for (int k = 1; k <= 6; k++)
         add_op(OP_ADD, 7 + k, 7, k, 16'h0);
      tab[n_rows-2].stall = 1'b1;
      // Flush with work in flight
      cur_test = 5;
      add_op(OP_MUL, 9, 1, 2, 16'h0);
      add_op(OP_ADD, 10, 9, 1, 16'h0);
      add_op(OP_ADD, 11, 9, 2, 16'h0);
      tab[n_rows-1].flush_after = 1'b1;
      add_op(OP_ADD, 12, 9, 10, 16'h0);
      add_op(OP_XOR, 13, 11, 1, 16'h0);
      add_op(OP_ADD, 15, 10, 11, 16'h0);
      // Pseudo-random mix over r0..r15
      cur_test = 6;
      seed = 32'hef28;
      for (int k = 0; k < 40; k++)
      begin
         seed = lcg_next(seed);
         pick = (seed >> 16) % 32'd5;
         seed = lcg_next(seed);
         add_op(op_e'(pick[2:0]), int'(seed[19:16]), int'(seed[23:20]),
                int'(seed[27:24]), seed[31:16]);
      end
   endtask

   task automatic present_row(input int r);
      i_uop     = tab[r].uop;
      i_uop.id  = row_id(r);
      i_valid   = 1'b1;
      stall_exp = tab[r].stall;
      ord_kind  = tab[r].ord_kind;
      ord_ref   = row_id(tab[r].ord_row);
   endtask

   // Hold i_valid until o_ready is high at an edge
   task automatic wait_accept();
      logic taken;
      taken = 1'b0;
      while (!taken)
      begin
         @(negedge clk);
         taken = o_ready;
         @(posedge clk);
      end
      #2;
      i_valid = 1'b0;
   endtask

   task automatic flush_pulse();
      i_flush = 1'b1;
      @(posedge clk);
      #2;
      i_flush = 1'b0;
   endtask

   task automatic finish_test(input int t);
      int n;
      n = 0;
      while (pending != 0 && n < DRAIN_MAX)
      begin
         @(posedge clk);
         #2;
         n++;
      end
      test_num = t;
      test_end = 1'b1;
      @(posedge clk);
      #2;
      test_end = 1'b0;
   endtask

   initial
   begin
      clk       = 1'b0;
      i_arst_n  = 1'b0;
      i_valid   = 1'b0;
      i_uop     = '0;
      i_flush   = 1'b0;
      stall_exp = 1'b0;
      ord_kind  = '0;
      ord_ref   = '0;
      test_end  = 1'b0;
      test_num  = 0;
      build_table();
      limit = 40 * n_rows;
      repeat (2) @(posedge clk);
      #2;
      i_arst_n = 1'b1;
      for (int r = 0; r < n_rows; r++)
      begin
         present_row(r);
         wait_accept();
         if (tab[r].flush_after)
            flush_pulse();
         if (r == n_rows - 1 || tab[r+1].test != tab[r].test)
            finish_test(tab[r].test);
      end
      @(posedge clk);
      #2;
      $display("Tests passed %0d, failed %0d", tests_pass, tests_fail);
      if (errors == 0 && tests_fail == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

//--- build.f
+incdir+include
logic/iq_pkg.sv
logic/operand_fetch.sv
logic/issue_queue.sv
logic/exec_unit.sv
logic/issue_top.sv
bench/issue_checker.sv
bench/tb_issue.sv

//--- include/iq_settings.svh
// ----------------------------------------------------------
// Width and depth settings for the issue slice
// Data, register address, micro-op id, queue depth, MUL latency
// ----------------------------------------------------------

`ifndef IQ_SETTINGS_SVH
`define IQ_SETTINGS_SVH

// Datapath word
`define IQ_DATA_W 32

// 32 architectural registers, r0 is nil
`define IQ_REG_AW 5

`define IQ_ID_W 4

// Issue queue entries
`define IQ_DEPTH 4

`define IQ_MUL_STAGES 3

`endif

//--- logic/exec_unit.sv
// ----------------------------------------------------------
// Execute stage
// One-cycle ALU, pipelined MUL, shared writeback port
// ----------------------------------------------------------

`include "iq_settings.svh"

module exec_unit
   import iq_pkg::*;
(
   input  logic    clk,
   input  logic    i_arst_n,
   input  issue_t  i_issue,
   input  logic    i_flush,
   output logic    o_ready,
   output bypass_t o_wb
);

   localparam int MS = `IQ_MUL_STAGES;
   localparam int W  = `IQ_DATA_W;

   logic                  is_mul;
   logic [W-1:0]          alu_res;
   logic [W-1:0]          mul_lo;
   logic                  alu_v;
   logic [`IQ_REG_AW-1:0] alu_rd;
   logic [`IQ_ID_W-1:0]   alu_id;
   logic [W-1:0]          alu_data;
   logic [MS-1:0]         mul_v;
   logic [`IQ_REG_AW-1:0] mul_rd   [MS];
   logic [`IQ_ID_W-1:0]   mul_id   [MS];
   logic [W-1:0]          mul_data [MS];

   assign is_mul = (i_issue.op == OP_MUL);
   // Low half of the product only
   assign mul_lo = i_issue.rs1_dat * i_issue.rs2_dat;

   // Hold off ALU work when a MUL takes the port next cycle
   assign o_ready = is_mul | ~mul_v[MS-2];

   always_comb
   begin
      case (i_issue.op)
         OP_ADD:  alu_res = i_issue.rs1_dat + i_issue.rs2_dat;
         OP_SUB:  alu_res = i_issue.rs1_dat - i_issue.rs2_dat;
         OP_XOR:  alu_res = i_issue.rs1_dat ^ i_issue.rs2_dat;
         OP_LI:   alu_res = {{(W-16){1'b0}}, i_issue.imm};
         default: alu_res = '0;
      endcase
   end

   always_ff @(posedge clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         alu_v <= 1'b0;
         mul_v <= '0;
      end
      else if (i_flush)
      begin
         alu_v <= 1'b0;
         mul_v <= '0;
      end
      else
      begin
         alu_v <= i_issue.valid & ~is_mul & o_ready;
         mul_v <= {mul_v[MS-2:0], i_issue.valid & is_mul};
      end
   end

   always_ff @(posedge clk)
   begin
      if (i_issue.valid && !is_mul)
      begin
         alu_rd   <= i_issue.rd;
         alu_id   <= i_issue.id;
         alu_data <= alu_res;
      end
      if (i_issue.valid && is_mul)
      begin
         mul_rd[0]   <= i_issue.rd;
         mul_id[0]   <= i_issue.id;
         mul_data[0] <= mul_lo;
      end
      // Product rides along the stages
      for (int s = 1; s < MS; s++)
      begin
         if (mul_v[s-1])
         begin
            mul_rd[s]   <= mul_rd[s-1];
            mul_id[s]   <= mul_id[s-1];
            mul_data[s] <= mul_data[s-1];
         end
      end
   end

   // ALU and MUL never valid together
   always_comb
   begin
      if (alu_v)
      begin
         o_wb.valid = 1'b1;
         o_wb.rd    = alu_rd;
         o_wb.id    = alu_id;
         o_wb.data  = alu_data;
      end
      else
      begin
         o_wb.valid = mul_v[MS-1];
         o_wb.rd    = mul_rd[MS-1];
         o_wb.id    = mul_id[MS-1];
         o_wb.data  = mul_data[MS-1];
      end
   end

endmodule

//--- logic/iq_pkg.sv
// ----------------------------------------------------------
// Shared types of the issue slice
// Opcode enum, operand union, dispatch/fetch/issue/writeback
// ----------------------------------------------------------

`include "iq_settings.svh"

package iq_pkg;

   typedef enum logic [2:0]
   {
      OP_ADD = 3'd0,
      OP_SUB = 3'd1,
      OP_XOR = 3'd2,
      OP_LI  = 3'd3,
      OP_MUL = 3'd4
   } op_e;

   typedef struct packed
   {
      op_e                   op;
      logic [`IQ_REG_AW-1:0] rd;
      logic [`IQ_REG_AW-1:0] rs1;
      logic [`IQ_REG_AW-1:0] rs2;
      logic [15:0]           imm;
      logic [`IQ_ID_W-1:0]   id;
   } uop_t;

   // Tag view of a waiting operand word
   typedef struct packed
   {
      logic [`IQ_DATA_W-`IQ_REG_AW-1:0] pad;
      logic [`IQ_REG_AW-1:0]            tag;
   } tag_view_t;

   typedef union packed
   {
      logic [`IQ_DATA_W-1:0] data;
      tag_view_t             tv;
   } operand_u;

   typedef struct packed
   {
      logic                  valid;
      op_e                   op;
      logic [`IQ_REG_AW-1:0] rd;
      logic [15:0]           imm;
      logic [`IQ_ID_W-1:0]   id;
      logic                  rs1_rdy;
      operand_u              rs1;
      logic                  rs2_rdy;
      operand_u              rs2;
   } fetched_t;

   typedef struct packed
   {
      logic                  valid;
      op_e                   op;
      logic [`IQ_REG_AW-1:0] rd;
      logic [15:0]           imm;
      logic [`IQ_ID_W-1:0]   id;
      logic [`IQ_DATA_W-1:0] rs1_dat;
      logic [`IQ_DATA_W-1:0] rs2_dat;
   } issue_t;

   // Writeback broadcast
   typedef struct packed
   {
      logic                  valid;
      logic [`IQ_REG_AW-1:0] rd;
      logic [`IQ_ID_W-1:0]   id;
      logic [`IQ_DATA_W-1:0] data;
   } bypass_t;

endpackage

//--- logic/issue_queue.sv
// ----------------------------------------------------------
// Out-of-order issue queue
// Lowest-free allocation, tag wake-up on writeback,
// lowest-ready select and AND-OR issue mux
// ----------------------------------------------------------

`include "iq_settings.svh"

module issue_queue
   import iq_pkg::*;
(
   input  logic     clk,
   input  logic     i_arst_n,
   input  fetched_t i_fetched,
   input  logic     i_accept,
   input  logic     i_flush,
   input  bypass_t  i_wb,
   input  logic     i_fu_ready,
   output logic     o_free,
   output issue_t   o_issue
);

   localparam int D = `IQ_DEPTH;
   localparam int W = `IQ_DATA_W;

   // Entry control
   logic [D-1:0]          q_valid;
   logic [D-1:0]          q_rs1_rdy;
   logic [D-1:0]          q_rs2_rdy;

   // Entry payload
   op_e                   q_op  [D];
   logic [`IQ_REG_AW-1:0] q_rd  [D];
   logic [15:0]           q_imm [D];
   logic [`IQ_ID_W-1:0]   q_id  [D];
   operand_u              q_rs1 [D];
   operand_u              q_rs2 [D];

   logic [D-1:0]          free;
   logic [D:0]            free_seen;
   logic [D-1:0]          ent_rdy;
   logic [D-1:0]          sel;
   logic [D:0]            rdy_seen;
   logic [D-1:0]          push;
   logic [D-1:0]          pop;
   logic [D-1:0]          wake1;
   logic [D-1:0]          wake2;
   logic                  push_any;
   logic                  wb_live;
   logic [2:0]            iss_op;

   assign push_any     = i_accept & i_fetched.valid;
   assign wb_live      = i_wb.valid & (i_wb.rd != '0);
   assign free_seen[0] = 1'b0;
   assign rdy_seen[0]  = 1'b0;

   for (genvar i = 0; i < D; i++)
   begin : g_ent
      // Allocate into the lowest free slot
      assign free[i]        = ~q_valid[i] & ~free_seen[i];
      assign free_seen[i+1] = free_seen[i] | ~q_valid[i];

      // Oldest position wins among ready entries
      assign ent_rdy[i]    = q_valid[i] & q_rs1_rdy[i] & q_rs2_rdy[i];
      assign sel[i]        = ent_rdy[i] & ~rdy_seen[i];
      assign rdy_seen[i+1] = rdy_seen[i] | ent_rdy[i];

      assign push[i] = push_any & free[i];
      assign pop[i]  = sel[i] & i_fu_ready;

      // Broadcast rd matches a waiting tag
      assign wake1[i] = q_valid[i] & ~q_rs1_rdy[i] & wb_live &
                        (i_wb.rd == q_rs1[i].tv.tag);
      assign wake2[i] = q_valid[i] & ~q_rs2_rdy[i] & wb_live &
                        (i_wb.rd == q_rs2[i].tv.tag);
   end

   // End of the free chain means some slot is empty
   assign o_free = free_seen[D];

   always_ff @(posedge clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         q_valid   <= '0;
         q_rs1_rdy <= '0;
         q_rs2_rdy <= '0;
      end
      else if (i_flush)
         q_valid <= '0;
      else
      begin
         for (int i = 0; i < D; i++)
         begin
            if (push[i])
            begin
               q_valid[i]   <= 1'b1;
               q_rs1_rdy[i] <= i_fetched.rs1_rdy;
               q_rs2_rdy[i] <= i_fetched.rs2_rdy;
            end
            else
            begin
               if (pop[i])
                  q_valid[i] <= 1'b0;
               if (wake1[i])
                  q_rs1_rdy[i] <= 1'b1;
               if (wake2[i])
                  q_rs2_rdy[i] <= 1'b1;
            end
         end
      end
   end

   // Operand word turns from tag to data on wake-up
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < D; i++)
      begin
         if (push[i])
         begin
            q_op[i]  <= i_fetched.op;
            q_rd[i]  <= i_fetched.rd;
            q_imm[i] <= i_fetched.imm;
            q_id[i]  <= i_fetched.id;
            q_rs1[i] <= i_fetched.rs1;
            q_rs2[i] <= i_fetched.rs2;
         end
         else
         begin
            if (wake1[i])
               q_rs1[i].data <= i_wb.data;
            if (wake2[i])
               q_rs2[i].data <= i_wb.data;
         end
      end
   end

   // One-hot sel makes the OR of masked entries a mux
   always_comb
   begin
      o_issue = '0;
      iss_op  = '0;
      for (int i = 0; i < D; i++)
      begin
         iss_op          |= {3{sel[i]}} & q_op[i];
         o_issue.rd      |= {`IQ_REG_AW{sel[i]}} & q_rd[i];
         o_issue.imm     |= {16{sel[i]}} & q_imm[i];
         o_issue.id      |= {`IQ_ID_W{sel[i]}} & q_id[i];
         o_issue.rs1_dat |= {W{sel[i]}} & q_rs1[i].data;
         o_issue.rs2_dat |= {W{sel[i]}} & q_rs2[i].data;
      end
      o_issue.valid = rdy_seen[D];
      o_issue.op    = op_e'(iss_op);
   end

endmodule

//--- logic/issue_top.sv
// ----------------------------------------------------------
// Top of the issue slice
// Fetch, issue queue and execute with writeback broadcast
// ----------------------------------------------------------

module issue_top
   import iq_pkg::*;
(
   input  logic    clk,
   input  logic    i_arst_n,
   input  logic    i_valid,
   input  uop_t    i_uop,
   input  logic    i_flush,
   output logic    o_ready,
   output bypass_t o_wb
);

   logic     accept;
   logic     queue_free;
   logic     fu_ready;
   fetched_t fetched;
   issue_t   issue;

   // Dispatch handshake
   assign accept = i_valid & o_ready;

   operand_fetch u_fetch (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_valid      (i_valid),
      .i_uop        (i_uop),
      .i_flush      (i_flush),
      .i_queue_free (queue_free),
      .i_wb         (o_wb),
      .o_ready      (o_ready),
      .o_fetched    (fetched)
   );

   issue_queue u_queue (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_fetched  (fetched),
      .i_accept   (accept),
      .i_flush    (i_flush),
      .i_wb       (o_wb),
      .i_fu_ready (fu_ready),
      .o_free     (queue_free),
      .o_issue    (issue)
   );

   exec_unit u_exec (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_issue  (issue),
      .i_flush  (i_flush),
      .o_ready  (fu_ready),
      .o_wb     (o_wb)
   );

endmodule

//--- logic/operand_fetch.sv
// ----------------------------------------------------------
// Operand fetch stage
// Register file with busy bits, destination stall,
// operand data/tag forming with writeback bypass
// ----------------------------------------------------------

`include "iq_settings.svh"

module operand_fetch
   import iq_pkg::*;
(
   input  logic     clk,
   input  logic     i_arst_n,
   input  logic     i_valid,
   input  uop_t     i_uop,
   input  logic     i_flush,
   input  logic     i_queue_free,
   input  bypass_t  i_wb,
   output logic     o_ready,
   output fetched_t o_fetched
);

   localparam int NREG = 1 << `IQ_REG_AW;

   logic [`IQ_DATA_W-1:0] regs [NREG];
   logic [NREG-1:0]       busy;
   logic                  rd_free;
   logic                  accept;
   logic                  wb_we;

   // Ready data, bypassed data, or the tag of the pending producer
   function automatic void form_operand(
      input  logic [`IQ_REG_AW-1:0] rs,
      input  logic                  no_src,
      output logic                  rdy,
      output operand_u              opnd
   );
      if (no_src || rs == '0)
      begin
         rdy       = 1'b1;
         opnd.data = '0;
      end
      else if (!busy[rs])
      begin
         rdy       = 1'b1;
         opnd.data = regs[rs];
      end
      else if (i_wb.valid && i_wb.rd == rs)
      begin
         rdy       = 1'b1;
         opnd.data = i_wb.data;
      end
      else
      begin
         rdy         = 1'b0;
         opnd.tv.pad = '0;
         opnd.tv.tag = rs;
      end
   endfunction

   // WAW hazard avoided by stalling on a busy destination
   assign rd_free = (i_uop.rd == '0) | ~busy[i_uop.rd];
   assign o_ready = i_queue_free & rd_free & ~i_flush;
   assign accept  = i_valid & o_ready;
   assign wb_we   = i_wb.valid & (i_wb.rd != '0);

   always_comb
   begin
      o_fetched.valid = i_valid;
      o_fetched.op    = i_uop.op;
      o_fetched.rd    = i_uop.rd;
      o_fetched.imm   = i_uop.imm;
      o_fetched.id    = i_uop.id;
      // LI takes no sources
      form_operand(i_uop.rs1, i_uop.op == OP_LI, o_fetched.rs1_rdy, o_fetched.rs1);
      form_operand(i_uop.rs2, i_uop.op == OP_LI, o_fetched.rs2_rdy, o_fetched.rs2);
   end

   always_ff @(posedge clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
         busy <= '0;
      else if (i_flush)
         busy <= '0;
      else
      begin
         if (wb_we)
            busy[i_wb.rd] <= 1'b0;
         if (accept && i_uop.rd != '0)
            busy[i_uop.rd] <= 1'b1;
      end
   end

   // Registers come up as zero; r0 is never written
   always_ff @(posedge clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         for (int i = 0; i < NREG; i++)
            regs[i] <= '0;
      end
      else if (wb_we)
         regs[i_wb.rd] <= i_wb.data;
   end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build the issue slice testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 -Wno-fatal --top-module tb_issue -f build.f -o sim_issue

out=$(./obj_dir/sim_issue)
echo "$out"

if echo "$out" | grep -qx "Done: no errors"; then
   exit 0
fi
exit 1
